// File: source/core_cfg_pkg.sv
package core_cfg_pkg;

   // datapath
   localparam int GRLEN        = 32;
   localparam int RF_ADDR_BITS = 5;

   localparam logic [GRLEN-1:0] PC_INIT = 32'h1c00_0000;

   // fetch block, one 16-byte aligned line of four words
   localparam int FETCH_WORDS = 4;
   localparam int BLOCK_BITS  = FETCH_WORDS * GRLEN;

   // instruction queue
   localparam int IQ_DEPTH    = 8;
   localparam int IQ_CNT_BITS = 4;   // holds 0..IQ_DEPTH
   localparam int IQ_PTR_BITS = 3;

   // fetch FSM codes
   localparam logic [1:0] FS_IDLE = 2'd0;
   localparam logic [1:0] FS_ADDR = 2'd1;   // req up, waiting addr_ok
   localparam logic [1:0] FS_DATA = 2'd2;   // accepted, waiting valid
   localparam logic [1:0] FS_DISC = 2'd3;   // stale request, drop its data

endpackage

// File: source/inst_fmt_pkg.sv
package inst_fmt_pkg;

   // one instruction word, seen as 3R or as 2RI12
   typedef union packed {
      struct packed {
         logic [16:0] opcode;
         logic [4:0]  rk;
         logic [4:0]  rj;
         logic [4:0]  rd;
      } r3;
      struct packed {
         logic [9:0]  opcode;
         logic [11:0] imm12;   // signed
         logic [4:0]  rj;
         logic [4:0]  rd;
      } ri12;
   } inst_word_t;

   // 3R
   localparam logic [16:0] OP_ADD_W = 17'h00020;

   // 2RI12
   localparam logic [9:0] OP_ADDI_W = 10'h00a;
   localparam logic [9:0] OP_B12    = 10'h0d8;   // pc relative, offset in words

endpackage

// File: source/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl (
   input  logic                                i_clk,
   input  logic                                i_rst,

   output logic                                o_inst_req,
   output logic [core_cfg_pkg::GRLEN-1:0]      o_inst_addr,
   input  logic                                i_inst_addr_ok,
   input  logic                                i_inst_valid,
   input  logic [1:0]                          i_inst_count,
   input  logic [core_cfg_pkg::BLOCK_BITS-1:0] i_inst_rdata,
   output logic                                o_inst_cancel,

   input  logic [core_cfg_pkg::IQ_CNT_BITS-1:0] i_iq_free,
   output logic                                o_push_valid,
   output logic [2:0]                          o_push_cnt,
   output logic [core_cfg_pkg::BLOCK_BITS-1:0] o_push_words,
   output logic [core_cfg_pkg::GRLEN-1:0]      o_push_pc,

   input  logic                                i_redirect,
   input  logic [core_cfg_pkg::GRLEN-1:0]      i_redirect_pc
);
   import core_cfg_pkg::*;

   logic [1:0]       state;
   logic [GRLEN-1:0] fetch_pc;
   logic [GRLEN-1:0] req_addr;
   logic             stale;       // redirected while still waiting for addr_ok
   logic [GRLEN-1:0] blk_bytes;

   assign o_inst_req    = (state == FS_ADDR);
   assign o_inst_addr   = req_addr;
   assign o_inst_cancel = i_redirect && (state == FS_DATA) && !i_inst_valid;

   // data landing together with a redirect is dropped, queue flushes anyway
   assign o_push_valid = (state == FS_DATA) && i_inst_valid && !i_redirect;
   assign o_push_cnt   = {1'b0, i_inst_count} + 3'd1;
   assign o_push_words = i_inst_rdata;
   assign o_push_pc    = req_addr;
   assign blk_bytes    = {{(GRLEN-5){1'b0}}, o_push_cnt, 2'b00};

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state <= FS_IDLE;
         stale <= 1'b0;
      end else begin
         stale <= (state == FS_ADDR) ? (stale || i_redirect) : 1'b0;
         case (state)
            FS_IDLE: begin
               if (!i_redirect && i_iq_free >= IQ_CNT_BITS'(FETCH_WORDS)) begin
                  state <= FS_ADDR;
               end
            end
            FS_ADDR: begin
               if (i_inst_addr_ok) begin
                  state <= (stale || i_redirect) ? FS_DISC : FS_DATA;
               end
            end
            FS_DATA: begin
               if (i_inst_valid || i_redirect) begin
                  state <= FS_IDLE;   // redirect without data is a cancel
               end
            end
            default: begin
               if (i_inst_valid) begin
                  state <= FS_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         fetch_pc <= PC_INIT;
      end else if (i_redirect) begin
         fetch_pc <= i_redirect_pc;
      end else if (o_push_valid) begin
         fetch_pc <= fetch_pc + blk_bytes;
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == FS_IDLE) begin
         req_addr <= fetch_pc;
      end
   end

   // memory returns data only for an accepted request
   a_valid_owed: assert property (@(posedge i_clk) disable iff (i_rst)
      i_inst_valid |-> (state == FS_DATA) || (state == FS_DISC));

endmodule

// File: source/inst_queue.sv
`timescale 1ns/1ps

module inst_queue (
   input  logic                                 i_clk,
   input  logic                                 i_rst,
   input  logic                                 i_flush,

   input  logic                                 i_push_valid,
   input  logic [2:0]                           i_push_cnt,
   input  logic [core_cfg_pkg::BLOCK_BITS-1:0]  i_push_words,
   input  logic [core_cfg_pkg::GRLEN-1:0]       i_push_pc,
   output logic [core_cfg_pkg::IQ_CNT_BITS-1:0] o_free,

   output logic                                 o_head_valid,
   output inst_fmt_pkg::inst_word_t             o_head_word,
   output logic [core_cfg_pkg::GRLEN-1:0]       o_head_pc,
   input  logic                                 i_pop
);
   import core_cfg_pkg::*;
   import inst_fmt_pkg::*;

   inst_word_t             word_mem [IQ_DEPTH];
   logic [GRLEN-1:0]       pc_mem [IQ_DEPTH];
   logic [IQ_PTR_BITS-1:0] wr_ptr;
   logic [IQ_PTR_BITS-1:0] rd_ptr;
   logic [IQ_CNT_BITS-1:0] count;
   logic [IQ_CNT_BITS-1:0] push_n;

   assign push_n       = i_push_valid ? IQ_CNT_BITS'(i_push_cnt) : '0;
   assign o_free       = IQ_CNT_BITS'(IQ_DEPTH) - count;
   assign o_head_valid = (count != '0);
   assign o_head_word  = word_mem[rd_ptr];
   assign o_head_pc    = pc_mem[rd_ptr];

   // slot k of the block goes k entries past the write pointer
   always_ff @(posedge i_clk) begin
      for (int k = 0; k < FETCH_WORDS; k++) begin
         if (i_push_valid && 3'(k) < i_push_cnt) begin
            word_mem[wr_ptr + IQ_PTR_BITS'(k)] <= i_push_words[k*GRLEN +: GRLEN];
            pc_mem[wr_ptr + IQ_PTR_BITS'(k)]   <= i_push_pc + GRLEN'(4 * k);
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (i_flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         wr_ptr <= wr_ptr + IQ_PTR_BITS'(push_n);
         rd_ptr <= rd_ptr + IQ_PTR_BITS'(i_pop);
         count  <= count + push_n - IQ_CNT_BITS'(i_pop);
      end
   end

   // fetch only requests with a full block of room
   a_no_overflow: assert property (@(posedge i_clk) disable iff (i_rst)
      i_push_valid && !i_flush |-> IQ_CNT_BITS'(i_push_cnt) <= o_free);

   a_no_underflow: assert property (@(posedge i_clk) disable iff (i_rst)
      i_pop |-> o_head_valid);

endmodule

// File: source/decode_issue.sv
`timescale 1ns/1ps

module decode_issue (
   input  logic                                  i_clk,
   input  logic                                  i_rst,

   input  logic                                  i_head_valid,
   input  inst_fmt_pkg::inst_word_t              i_head_word,
   input  logic [core_cfg_pkg::GRLEN-1:0]        i_head_pc,
   output logic                                  o_pop,

   output logic                                  o_issue_valid,
   output logic [core_cfg_pkg::GRLEN-1:0]        o_issue_pc,
   output logic [core_cfg_pkg::RF_ADDR_BITS-1:0] o_issue_rd,
   output logic                                  o_issue_rf_wen,
   output logic [core_cfg_pkg::GRLEN-1:0]        o_issue_imm,
   input  logic                                  i_issue_ready,

   output logic                                  o_redirect,
   output logic [core_cfg_pkg::GRLEN-1:0]        o_redirect_pc
);
   import core_cfg_pkg::*;
   import inst_fmt_pkg::*;

   logic                    is_add;
   logic                    is_addi;
   logic                    is_br;
   logic [GRLEN-1:0]        imm_sext;
   logic [RF_ADDR_BITS-1:0] dec_rd;
   logic                    dec_wen;
   logic [GRLEN-1:0]        dec_imm;
   logic                    issue_br;
   logic                    br_taken;
   logic                    can_load;

   assign is_add   = (i_head_word.r3.opcode == OP_ADD_W);
   assign is_addi  = (i_head_word.ri12.opcode == OP_ADDI_W);
   assign is_br    = (i_head_word.ri12.opcode == OP_B12);
   assign imm_sext = {{(GRLEN-12){i_head_word.ri12.imm12[11]}}, i_head_word.ri12.imm12};

   always_comb begin
      dec_rd  = '0;
      dec_wen = 1'b0;
      dec_imm = '0;
      if (is_add) begin
         dec_rd  = i_head_word.r3.rd;
         dec_wen = 1'b1;
      end else if (is_addi) begin
         dec_rd  = i_head_word.ri12.rd;
         dec_wen = 1'b1;
         dec_imm = imm_sext;
      end else if (is_br) begin
         dec_imm = imm_sext;
      end
   end

   // nothing behind a branch enters until the flush has gone through
   assign br_taken = o_issue_valid && issue_br && i_issue_ready;
   assign can_load = !o_issue_valid || (i_issue_ready && !issue_br);
   assign o_pop    = i_head_valid && !o_redirect && can_load;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_issue_valid <= 1'b0;
         o_redirect    <= 1'b0;
      end else begin
         o_redirect <= br_taken;
         if (o_pop) begin
            o_issue_valid <= 1'b1;
         end else if (i_issue_ready) begin
            o_issue_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (o_pop) begin
         o_issue_pc     <= i_head_pc;
         o_issue_rd     <= dec_rd;
         o_issue_rf_wen <= dec_wen;
         o_issue_imm    <= dec_imm;
         issue_br       <= is_br;
      end
      if (br_taken) begin
         o_redirect_pc <= o_issue_pc + {o_issue_imm[GRLEN-3:0], 2'b00};   // offset in words
      end
   end

   // an unpopped head stays put unless a flush is on its way
   a_head_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      i_head_valid && !o_pop && !o_redirect |=> i_head_valid && $stable(i_head_pc)
         && $stable(i_head_word));

endmodule

// File: source/cpu_front.sv
`timescale 1ns/1ps

module cpu_front (
   input  logic                                  i_clk,
   input  logic                                  i_rst,

   output logic                                  o_inst_req,
   output logic [core_cfg_pkg::GRLEN-1:0]        o_inst_addr,
   input  logic                                  i_inst_addr_ok,
   input  logic                                  i_inst_valid,
   input  logic [1:0]                            i_inst_count,
   input  logic [core_cfg_pkg::BLOCK_BITS-1:0]   i_inst_rdata,
   output logic                                  o_inst_cancel,

   output logic                                  o_issue_valid,
   output logic [core_cfg_pkg::GRLEN-1:0]        o_issue_pc,
   output logic [core_cfg_pkg::RF_ADDR_BITS-1:0] o_issue_rd,
   output logic                                  o_issue_rf_wen,
   output logic [core_cfg_pkg::GRLEN-1:0]        o_issue_imm,
   input  logic                                  i_issue_ready
);
   import core_cfg_pkg::*;
   import inst_fmt_pkg::*;

   logic                   push_valid;
   logic [2:0]             push_cnt;
   logic [BLOCK_BITS-1:0]  push_words;
   logic [GRLEN-1:0]       push_pc;
   logic [IQ_CNT_BITS-1:0] iq_free;
   logic                   head_valid;
   inst_word_t             head_word;
   logic [GRLEN-1:0]       head_pc;
   logic                   pop;
   logic                   redirect;
   logic [GRLEN-1:0]       redirect_pc;

   fetch_ctrl u_fetch (
      .i_clk, .i_rst,
      .o_inst_req, .o_inst_addr, .i_inst_addr_ok, .i_inst_valid,
      .i_inst_count, .i_inst_rdata, .o_inst_cancel,
      .i_iq_free     (iq_free),
      .o_push_valid  (push_valid),
      .o_push_cnt    (push_cnt),
      .o_push_words  (push_words),
      .o_push_pc     (push_pc),
      .i_redirect    (redirect),
      .i_redirect_pc (redirect_pc)
   );

   inst_queue u_iq (
      .i_clk, .i_rst,
      .i_flush      (redirect),   // same edge the fetch PC moves
      .i_push_valid (push_valid),
      .i_push_cnt   (push_cnt),
      .i_push_words (push_words),
      .i_push_pc    (push_pc),
      .o_free       (iq_free),
      .o_head_valid (head_valid),
      .o_head_word  (head_word),
      .o_head_pc    (head_pc),
      .i_pop        (pop)
   );

   decode_issue u_dec (
      .i_clk, .i_rst,
      .i_head_valid  (head_valid),
      .i_head_word   (head_word),
      .i_head_pc     (head_pc),
      .o_pop         (pop),
      .o_issue_valid, .o_issue_pc, .o_issue_rd, .o_issue_rf_wen,
      .o_issue_imm, .i_issue_ready,
      .o_redirect    (redirect),
      .o_redirect_pc (redirect_pc)
   );

endmodule

// File: tb/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// compare tasks, one per kind of issue field
task automatic check_pc(input string name, input logic [GRLEN-1:0] want,
                        input logic [GRLEN-1:0] got);
   if (got !== want) begin
      stop_run($sformatf("error at %0t: %s expected %h got %h", $time, name, want, got));
   end
endtask

task automatic check_rd(input string name, input logic [RF_ADDR_BITS-1:0] want,
                        input logic [RF_ADDR_BITS-1:0] got);
   if (got !== want) begin
      stop_run($sformatf("error at %0t: %s expected %0d got %0d", $time, name, want, got));
   end
endtask

task automatic check_wen(input string name, input logic want, input logic got);
   if (got !== want) begin
      stop_run($sformatf("error at %0t: %s expected %b got %b", $time, name, want, got));
   end
endtask

task automatic check_imm(input string name, input logic [GRLEN-1:0] want,
                         input logic [GRLEN-1:0] got);
   if (got !== want) begin
      stop_run($sformatf("error at %0t: %s expected %h got %h", $time, name, want, got));
   end
endtask

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
   logic [31:0] y;
   y = x ^ (x << 13);
   y = y ^ (y >> 17);
   y = y ^ (y << 5);
   return y;
endfunction

`endif

// File: tb/tb_cpu_front.sv
`timescale 1ns/1ps

module tb_cpu_front;
   import core_cfg_pkg::*;
   import inst_fmt_pkg::*;

   localparam int          TD_WORDS = 128;
   localparam logic [31:0] END_MARK = 32'hffff_ffff;

   logic                    clk          = 1'b0;
   logic                    rst          = 1'b1;
   logic                    inst_req;
   logic [GRLEN-1:0]        inst_addr;
   logic                    inst_addr_ok = 1'b0;
   logic                    inst_valid   = 1'b0;
   logic [1:0]              inst_count   = '0;
   logic [BLOCK_BITS-1:0]   inst_rdata   = '0;
   logic                    inst_cancel;
   logic                    issue_valid;
   logic [GRLEN-1:0]        issue_pc;
   logic [RF_ADDR_BITS-1:0] issue_rd;
   logic                    issue_rf_wen;
   logic [GRLEN-1:0]        issue_imm;
   logic                    issue_ready  = 1'b0;

   logic [31:0] tdata [TD_WORDS];
   logic [31:0] prog [logic [31:0]];   // program image by address
   logic [31:0] exp_pc [$];
   int          n_exp      = 0;
   int          n_issued   = 0;
   int          limit      = 0;
   int          cycles     = 0;

   logic [31:0] mem_rng    = 32'd91858;
   logic [31:0] sink_rng   = 32'd91858 ^ 32'h9e37_79b9;
   logic        mem_busy   = 1'b0;     // accepted, block still owed
   logic        req_seen   = 1'b0;     // req up, addr_ok not yet given
   logic        first_req  = 1'b1;
   logic [31:0] held_addr;
   logic [31:0] pend_addr;
   int          ok_wait    = 0;
   int          data_wait  = 0;
   int          stall_left = 0;

   always #2 clk = ~clk;

   cpu_front dut0 (
      .i_clk          (clk),          .i_rst          (rst),
      .o_inst_req     (inst_req),     .o_inst_addr    (inst_addr),
      .i_inst_addr_ok (inst_addr_ok), .i_inst_valid   (inst_valid),
      .i_inst_count   (inst_count),   .i_inst_rdata   (inst_rdata),
      .o_inst_cancel  (inst_cancel),  .o_issue_valid  (issue_valid),
      .o_issue_pc     (issue_pc),     .o_issue_rd     (issue_rd),
      .o_issue_rf_wen (issue_rf_wen), .o_issue_imm    (issue_imm),
      .i_issue_ready  (issue_ready)
   );

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1);
   endtask

   `include "tb_checks.svh"

   function automatic logic [31:0] mem_word(input logic [31:0] addr);
      if (prog.exists(addr)) begin
         return prog[addr];
      end
      return addr ^ 32'hfff0_0000;   // decodes as unknown near the image
   endfunction

   // expected issue fields, straight from the decode table
   task automatic ref_decode(input inst_word_t w, output logic [RF_ADDR_BITS-1:0] rd,
                             output logic wen, output logic [GRLEN-1:0] imm);
      rd  = '0;
      wen = 1'b0;
      imm = '0;
      if (w.r3.opcode == OP_ADD_W) begin
         rd  = w.r3.rd;
         wen = 1'b1;
      end else if (w.ri12.opcode == OP_ADDI_W || w.ri12.opcode == OP_B12) begin
         imm = {{(GRLEN-12){w.ri12.imm12[11]}}, w.ri12.imm12};
         if (w.ri12.opcode == OP_ADDI_W) begin
            rd  = w.ri12.rd;
            wen = 1'b1;
         end
      end
   endtask

   task automatic load_testdata();
      int i;
      for (i = 0; i < TD_WORDS; i++) begin
         tdata[i] = END_MARK;
      end
      $readmemh("tb/front_testdata.txt", tdata);
      i = 0;
      while (i + 1 < TD_WORDS && tdata[i] != END_MARK) begin
         prog[tdata[i]] = tdata[i+1];
         i += 2;
      end
      i++;
      while (i < TD_WORDS && tdata[i] != END_MARK) begin
         exp_pc.push_back(tdata[i]);
         i++;
      end
      n_exp = exp_pc.size();
      if (n_exp == 0) begin
         stop_run("test data file holds no expected issue PCs");
      end
   endtask

   // instruction memory, one request at a time
   always @(posedge clk) begin
      if (rst) begin
         inst_addr_ok <= 1'b0;
         inst_valid   <= 1'b0;
      end else begin
         inst_addr_ok <= 1'b0;
         inst_valid   <= 1'b0;
         if (inst_cancel) begin
            if (!mem_busy) begin
               stop_run("cancel raised with no fetch in flight");
            end
            mem_busy = 1'b0;   // pending block dropped
         end else if (mem_busy) begin
            if (data_wait > 0) begin
               data_wait--;
            end else begin
               mem_rng = xorshift32(mem_rng);
               inst_count <= 2'(mem_rng % (32'd4 - 32'(pend_addr[3:2])));   // stay in block
               for (int k = 0; k < FETCH_WORDS; k++) begin
                  inst_rdata[k*GRLEN +: GRLEN] <= mem_word(pend_addr + 32'(4 * k));
               end
               inst_valid <= 1'b1;
               mem_busy = 1'b0;
            end
         end
         if (inst_req) begin
            if (first_req) begin
               check_pc("o_inst_addr", PC_INIT, inst_addr);
            end
            first_req = 1'b0;
            if (mem_busy) begin
               stop_run("second fetch request while one is outstanding");
            end
            if (req_seen && inst_addr !== held_addr) begin
               stop_run("fetch address changed before addr_ok");
            end
            if (inst_addr_ok) begin
               req_seen  = 1'b0;
               mem_busy  = 1'b1;
               pend_addr = inst_addr;
               mem_rng   = xorshift32(mem_rng);
               data_wait = int'(mem_rng % 4);
            end else begin
               if (!req_seen) begin
                  req_seen  = 1'b1;
                  held_addr = inst_addr;
                  mem_rng   = xorshift32(mem_rng);
                  ok_wait   = int'(mem_rng % 4);
               end
               if (ok_wait == 0) begin
                  inst_addr_ok <= 1'b1;
               end else begin
                  ok_wait--;
               end
            end
         end else if (req_seen) begin
            stop_run("fetch request withdrawn before addr_ok");
         end
      end
   end

   // issue sink and checker
   always @(posedge clk) begin : sink_proc
      logic [RF_ADDR_BITS-1:0] rd;
      logic                    wen;
      logic [GRLEN-1:0]        imm;
      if (rst) begin
         issue_ready <= 1'b0;
      end else begin
         if (issue_valid && issue_ready && n_issued < n_exp) begin
            ref_decode(mem_word(exp_pc[n_issued]), rd, wen, imm);
            check_pc("o_issue_pc", exp_pc[n_issued], issue_pc);
            check_rd("o_issue_rd", rd, issue_rd);
            check_wen("o_issue_rf_wen", wen, issue_rf_wen);
            check_imm("o_issue_imm", imm, issue_imm);
            n_issued++;
         end
         sink_rng = xorshift32(sink_rng);
         if (stall_left > 0) begin
            stall_left--;
            issue_ready <= 1'b0;
         end else if (sink_rng[4:0] == 5'd0) begin
            stall_left = 8 + int'(sink_rng[9:5]);   // long stall, queue fills up
            issue_ready <= 1'b0;
         end else begin
            issue_ready <= (sink_rng[6:5] != 2'd0);
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (limit > 0 && cycles > limit) begin
         stop_run($sformatf("timeout after %0d cycles, %0d of %0d instructions issued",
                            cycles, n_issued, n_exp));
      end
   end

   initial begin
      load_testdata();
      limit = n_exp * 40 + 200;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      wait (n_issued == n_exp);
      $display("Test passed");
      $finish;
   end

endmodule

// File: tb/front_testdata.txt
// program image: address word, one pair per line, closed by ffffffff
// then the expected issue PCs in order, closed by ffffffff
1c000000 02801401
1c000004 02bff422
1c000008 001018a4
1c00000c 12345678
1c000010 029ffc03
1c000014 36001000
1c000018 02800405
1c00001c 02800806
1c000020 02800c07
1c000024 00102507
1c000028 02bffc08
1c00002c 36000800
1c000030 02800409
1c000034 02a0000a
1c000038 363fe000
ffffffff
1c000000 1c000004 1c000008 1c00000c
1c000010 1c000014 1c000024 1c000028
1c00002c 1c000034 1c000038 1c000018
1c00001c 1c000020 1c000024 1c000028
1c00002c 1c000034 1c000038 1c000018
ffffffff

// File: list.f
+incdir+tb
source/core_cfg_pkg.sv
source/inst_fmt_pkg.sv
source/fetch_ctrl.sv
source/inst_queue.sv
source/decode_issue.sv
source/cpu_front.sv
tb/tb_cpu_front.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the front end testbench
set -e
cd "$(dirname "$0")"

TOP=tb_cpu_front
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" -f list.f

./obj_dir/V"$TOP" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "Test passed" "$LOG"; then
   echo "simulation PASS"
else
   echo "simulation FAIL"
   exit 1
fi
